//--- cpu.f
cpuPkg.sv
memReqIf.sv
fetchStage.sv
hazardDetect.sv
regFile.sv
decodeStage.sv
forwardUnit.sv
executeStage.sv
memoryStage.sv
cpu.sv
cpuTb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f cpu.f -o cpuTb
	./obj_dir/cpuTb

clean:
	rm -rf obj_dir

//--- cpuTb.sv
`default_nettype none

module cpuTb;
	import cpuPkg::*;

	localparam int memWords = 256;
	localparam int numTests = 5;
	localparam int maxProgLen = 60;
	// Six cycles per instruction covers stalls and flushes, plus reset and drain
	localparam int cycleLimit = numTests * (maxProgLen * 6 + 40);
	localparam logic [15:0] haltWord = {opHlt, 12'h000};

	logic clk;
	logic rst;
	logic [15:0] pc;
	logic [15:0] instr;
	logic [15:0] dmemAddr;
	logic [15:0] dmemWData;
	logic dmemWe;
	logic [15:0] dmemRData;
	logic hlt;

	// Harvard memory models
	logic [15:0] imem [memWords];
	logic [15:0] dmem [memWords];

	int progLen;
	int cycleCount = 0;
	integer seed = 32'h6d51_06aa;

	// Stores seen on the data port, and the ones the program should make
	logic [15:0] storeAddrLog [$];
	logic [15:0] storeDataLog [$];
	logic [15:0] expAddr [$];
	logic [15:0] expData [$];

	cpu u_dut (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.instr(instr),
		.dmemAddr(dmemAddr),
		.dmemWData(dmemWData),
		.dmemWe(dmemWe),
		.dmemRData(dmemRData),
		.hlt(hlt)
	);

	// Both memories answer in the same cycle
	assign instr = imem[pc[7:0]];
	assign dmemRData = dmem[dmemAddr[7:0]];

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// Port is stable mid-cycle, so stores are taken at the falling edge
	always @(negedge clk) begin
		if (dmemWe === 1'b1) begin
			dmem[dmemAddr[7:0]] <= dmemWData;
			storeAddrLog.push_back(dmemAddr);
			storeDataLog.push_back(dmemWData);
		end
	end

	// Hang guard over the whole run
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Something failed");
			$fatal(1, "Timeout, core never halted");
		end
	end

	task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at time %0t: %s, got %h, expected %h", $time, what, actual,
				expected);
			$display("Something failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Instruction encoders
	function automatic logic [15:0] aluOpWord(input opcode op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] lowByteWord(input logic [3:0] rd, input logic [7:0] imm);
		return {opLlb, rd, imm};
	endfunction

	function automatic logic [15:0] highByteWord(input logic [3:0] rd, input logic [7:0] imm);
		return {opLhb, rd, imm};
	endfunction

	function automatic logic [15:0] loadWord(input logic [3:0] rd, input logic [3:0] base,
		input logic [3:0] off);
		return {opLw, rd, base, off};
	endfunction

	function automatic logic [15:0] storeWord(input logic [3:0] src, input logic [3:0] base,
		input logic [3:0] off);
		return {opSw, src, base, off};
	endfunction

	function automatic logic [15:0] branchWord(input condCode cond, input logic [8:0] off);
		return {opBr, cond, off};
	endfunction

	// Preset data word, both bytes follow the address
	function automatic logic [15:0] dataFill(input logic [7:0] addr);
		return {~addr, addr};
	endfunction

	task automatic randomByte(output logic [7:0] b);
		b = 8'($random(seed));
	endtask

	task automatic newProgram;
		for (int i = 0; i < memWords; i++) begin
			// Unused opcode carrying its own address
			imem[i] = {4'hE, 4'h0, 8'(i)};
			dmem[i] = dataFill(8'(i));
		end
		progLen = 0;
		expAddr.delete();
		expData.delete();
	endtask

	task automatic emit(input logic [15:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	task automatic expectStore(input logic [15:0] addr, input logic [15:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	// Three reset edges, then the log starts empty
	task automatic applyReset;
		@(posedge clk);
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		storeAddrLog.delete();
		storeDataLog.delete();
	endtask

	task automatic runUntilHalt;
		while (hlt !== 1'b1) begin
			@(negedge clk);
		end
		// A few more cycles to catch late stores
		repeat (3) @(negedge clk);
	endtask

	task automatic compareStores(input string testName);
		checkEq(storeAddrLog.size(), expAddr.size(), {testName, ": number of stores"});
		for (int i = 0; i < expAddr.size(); i++) begin
			checkEq(storeAddrLog[i], expAddr[i],
				$sformatf("%s: address of store %0d", testName, i));
			checkEq(storeDataLog[i], expData[i],
				$sformatf("%s: data of store %0d", testName, i));
		end
	endtask

	// Each result feeds the next instruction
	task automatic aluChainTest;
		logic [7:0] aLo;
		logic [7:0] aHi;
		logic [7:0] bLo;
		logic [7:0] bHi;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sum;
		logic [15:0] diff;
		logic [15:0] conj;
		logic [15:0] mix;
		logic [15:0] dbl;
		randomByte(aLo);
		randomByte(aHi);
		randomByte(bLo);
		randomByte(bHi);
		a = {aHi, aLo};
		b = {bHi, bLo};
		sum = a + b;
		diff = sum - a;
		conj = diff & sum;
		mix = conj ^ b;
		dbl = mix + mix;
		newProgram();
		emit(lowByteWord(1, aLo));
		emit(highByteWord(1, aHi));
		emit(lowByteWord(2, bLo));
		emit(highByteWord(2, bHi));
		emit(lowByteWord(3, 8'h10));
		emit(aluOpWord(opAdd, 4, 1, 2));
		emit(aluOpWord(opSub, 5, 4, 1));
		// One operand from memory stage, one from writeback
		emit(aluOpWord(opAnd, 6, 5, 4));
		emit(aluOpWord(opXor, 7, 6, 2));
		emit(aluOpWord(opAdd, 8, 7, 7));
		// Store data taken straight from the memory stage
		emit(storeWord(8, 3, 4));
		emit(storeWord(4, 3, 0));
		emit(storeWord(5, 3, 1));
		emit(storeWord(6, 3, 2));
		emit(storeWord(7, 3, 3));
		// r0 drops the sum and still reads zero
		emit(aluOpWord(opAdd, 0, 1, 2));
		emit(storeWord(0, 3, 5));
		emit(haltWord);
		expectStore(16'h0014, dbl);
		expectStore(16'h0010, sum);
		expectStore(16'h0011, diff);
		expectStore(16'h0012, conj);
		expectStore(16'h0013, mix);
		expectStore(16'h0015, 16'h0000);
		applyReset();
		runUntilHalt();
		compareStores("ALU chain");
	endtask

	task automatic loadUseTest;
		logic [7:0] lo;
		logic [7:0] hi;
		logic [7:0] addend;
		logic [15:0] v1;
		logic [15:0] total;
		randomByte(lo);
		randomByte(hi);
		randomByte(addend);
		v1 = {hi, lo};
		total = v1 + {8'h00, addend};
		newProgram();
		emit(lowByteWord(1, lo));
		emit(highByteWord(1, hi));
		emit(lowByteWord(2, addend));
		emit(lowByteWord(3, 8'h20));
		emit(storeWord(1, 3, 0));
		emit(loadWord(4, 3, 0));
		// Load result used right away
		emit(aluOpWord(opAdd, 5, 4, 2));
		emit(storeWord(5, 3, 1));
		emit(loadWord(6, 3, 1));
		// Loaded word as store data
		emit(storeWord(6, 3, 2));
		// Word preset in memory at address 5
		emit(loadWord(7, 0, 5));
		emit(aluOpWord(opAdd, 8, 7, 7));
		emit(storeWord(8, 3, 3));
		emit(haltWord);
		expectStore(16'h0020, v1);
		expectStore(16'h0021, total);
		expectStore(16'h0022, total);
		expectStore(16'h0023, dataFill(8'd5) + dataFill(8'd5));
		applyReset();
		runUntilHalt();
		compareStores("Load-use");
	endtask

	// Both slots behind the branch hold markers
	task automatic takenBranch(input condCode cond);
		emit(branchWord(cond, 9'd2));
		emit(storeWord(6, 3, 8));
		emit(storeWord(6, 3, 9));
	endtask

	// Store must show up when the branch falls through
	task automatic untakenBranch(input condCode cond, input logic [3:0] slot);
		emit(branchWord(cond, 9'd1));
		emit(storeWord(7, 3, slot));
		expectStore(16'h0040 + slot, 16'h0077);
	endtask

	task automatic branchTest;
		newProgram();
		emit(lowByteWord(1, 8'h05));
		emit(lowByteWord(2, 8'h03));
		emit(lowByteWord(3, 8'h40));
		emit(lowByteWord(4, 8'hFF));
		emit(highByteWord(4, 8'h7F));
		emit(lowByteWord(5, 8'hFF));
		emit(highByteWord(5, 8'hFF));
		// Marker value
		emit(lowByteWord(6, 8'hBD));
		emit(highByteWord(6, 8'hBA));
		emit(lowByteWord(7, 8'h77));
		// 5 - 5, zero
		emit(aluOpWord(opSub, 0, 1, 1));
		takenBranch(condEq);
		takenBranch(condGe);
		takenBranch(condLe);
		takenBranch(condAl);
		untakenBranch(condNe, 0);
		untakenBranch(condGt, 1);
		untakenBranch(condOv, 2);
		// 3 - 5, negative
		emit(aluOpWord(opSub, 0, 2, 1));
		takenBranch(condNe);
		takenBranch(condLt);
		untakenBranch(condEq, 3);
		untakenBranch(condGe, 4);
		// 5 - 3, positive
		emit(aluOpWord(opSub, 0, 1, 2));
		takenBranch(condGt);
		untakenBranch(condLt, 5);
		untakenBranch(condLe, 6);
		// 0x7FFF - 0xFFFF overflows
		emit(aluOpWord(opSub, 0, 4, 5));
		takenBranch(condOv);
		// Backward loop counting 3 down to 0
		emit(aluOpWord(opAdd, 8, 2, 0));
		emit(lowByteWord(9, 8'h01));
		emit(aluOpWord(opSub, 8, 8, 9));
		emit(storeWord(8, 3, 15));
		emit(branchWord(condNe, -9'sd3));
		// Flushed while the loop is taken
		emit(haltWord);
		expectStore(16'h004F, 16'h0002);
		expectStore(16'h004F, 16'h0001);
		expectStore(16'h004F, 16'h0000);
		applyReset();
		runUntilHalt();
		compareStores("Branches");
	endtask

	task automatic haltTest;
		int haltAt;
		logic [15:0] frozenPc;
		newProgram();
		emit(lowByteWord(1, 8'h3C));
		emit(lowByteWord(3, 8'h50));
		emit(storeWord(1, 3, 0));
		emit(aluOpWord(opAdd, 2, 1, 1));
		emit(storeWord(2, 3, 1));
		haltAt = progLen;
		emit(haltWord);
		// Never executed
		emit(storeWord(1, 3, 2));
		emit(storeWord(2, 3, 3));
		emit(lowByteWord(1, 8'h99));
		emit(storeWord(1, 3, 4));
		expectStore(16'h0050, 16'h003C);
		expectStore(16'h0051, 16'h0078);
		applyReset();
		runUntilHalt();
		frozenPc = pc;
		// PC stops on the word after HLT
		checkEq(frozenPc, haltAt + 1, "Halt: frozen pc");
		repeat (10) begin
			@(negedge clk);
			checkEq(hlt, 1'b1, "Halt: hlt dropped");
			checkEq(pc, frozenPc, "Halt: pc moved");
			checkEq(storeAddrLog.size(), 2, "Halt: store after HLT");
		end
		compareStores("Halt");
	endtask

	task automatic resetRerunTest;
		logic [7:0] x;
		randomByte(x);
		newProgram();
		emit(lowByteWord(1, x));
		emit(lowByteWord(3, 8'h60));
		emit(storeWord(1, 3, 0));
		emit(lowByteWord(8, 8'h08));
		emit(lowByteWord(9, 8'h01));
		// Loop keeps the core busy
		emit(aluOpWord(opSub, 8, 8, 9));
		emit(branchWord(condNe, -9'sd2));
		emit(storeWord(8, 3, 1));
		emit(aluOpWord(opAdd, 2, 1, 1));
		emit(storeWord(2, 3, 2));
		emit(haltWord);
		expectStore(16'h0060, {8'h00, x});
		expectStore(16'h0061, 16'h0000);
		expectStore(16'h0062, {8'h00, x} + {8'h00, x});
		applyReset();
		@(negedge clk);
		// Halt test left hlt high
		checkEq(hlt, 1'b0, "Reset: hlt after halted run");
		while (storeAddrLog.size() == 0) begin
			@(negedge clk);
		end
		// Somewhere inside the loop
		repeat (5) @(negedge clk);
		checkEq(hlt, 1'b0, "Reset: halted too early");
		applyReset();
		@(negedge clk);
		checkEq(pc, 16'h0000, "Reset: pc after reset");
		checkEq(hlt, 1'b0, "Reset: hlt after reset");
		runUntilHalt();
		compareStores("Reset rerun");
	endtask

	initial begin
		rst = 1'b1;
		aluChainTest();
		loadUseTest();
		branchTest();
		haltTest();
		resetRerunTest();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu.sv
`default_nettype none

module cpu (
	input  logic clk,
	input  logic rst,
	output logic [cpuPkg::dataWidth-1:0] pc,
	input  logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] dmemAddr,
	output logic [cpuPkg::dataWidth-1:0] dmemWData,
	output logic dmemWe,
	input  logic [cpuPkg::dataWidth-1:0] dmemRData,
	output logic hlt
);
	import cpuPkg::*;

	// IF/ID
	logic [dataWidth-1:0] instrId;
	logic [dataWidth-1:0] pcId;
	// Decode side of the hazard check
	logic [regAddrWidth-1:0] rsId;
	logic [regAddrWidth-1:0] rtId;
	logic usesRt;
	logic stall;
	logic halt;
	// ID/EX
	ctrlSig ctrlEx;
	logic [regAddrWidth-1:0] rsEx;
	logic [regAddrWidth-1:0] rtEx;
	logic [regAddrWidth-1:0] rdEx;
	logic [dataWidth-1:0] opAEx;
	logic [dataWidth-1:0] opBEx;
	logic [dataWidth-1:0] immEx;
	condCode condEx;
	logic [dataWidth-1:0] pcEx;
	// Redirect from execute
	logic brTaken;
	logic [dataWidth-1:0] brTarget;
	// EX/MEM
	ctrlSig ctrlMem;
	logic [regAddrWidth-1:0] rdMem;
	logic [dataWidth-1:0] resMem;
	// Writeback triple
	logic wbWe;
	logic [regAddrWidth-1:0] wbRd;
	logic [dataWidth-1:0] wbData;

	memReqIf memReq ();

	fetchStage fetch (
		.clk(clk), .rst(rst), .stall(stall), .halt(halt),
		.brTaken(brTaken), .brTarget(brTarget), .instr(instr),
		.pc(pc), .instrId(instrId), .pcId(pcId)
	);

	hazardDetect hazard (
		.clk(clk), .rst(rst), .brTaken(brTaken),
		.rsId(rsId), .rtId(rtId), .usesRt(usesRt),
		.rdEx(rdEx), .memReadEx(ctrlEx.memRead), .stall(stall)
	);

	// Branch redirect doubles as the decode flush
	decodeStage decode (
		.clk(clk), .rst(rst), .instrId(instrId), .pcId(pcId),
		.stall(stall), .flush(brTaken),
		.wbWe(wbWe), .wbRd(wbRd), .wbData(wbData), .halt(halt),
		.rsId(rsId), .rtId(rtId), .usesRt(usesRt),
		.ctrlEx(ctrlEx), .rsEx(rsEx), .rtEx(rtEx), .rdEx(rdEx),
		.opAEx(opAEx), .opBEx(opBEx), .immEx(immEx), .condEx(condEx), .pcEx(pcEx)
	);

	executeStage execute (
		.clk(clk), .rst(rst), .ctrlEx(ctrlEx),
		.rsEx(rsEx), .rtEx(rtEx), .rdEx(rdEx),
		.opAEx(opAEx), .opBEx(opBEx), .immEx(immEx), .condEx(condEx), .pcEx(pcEx),
		.wbData(wbData), .wbWe(wbWe), .wbRd(wbRd),
		.brTaken(brTaken), .brTarget(brTarget), .memReq(memReq.requester),
		.rdMem(rdMem), .ctrlMem(ctrlMem), .resMem(resMem)
	);

	memoryStage memory (
		.clk(clk), .rst(rst), .memReq(memReq.responder),
		.ctrlMem(ctrlMem), .rdMem(rdMem), .resMem(resMem),
		.dmemAddr(dmemAddr), .dmemWData(dmemWData), .dmemWe(dmemWe),
		.dmemRData(dmemRData),
		.wbWe(wbWe), .wbRd(wbRd), .wbData(wbData), .hlt(hlt)
	);

endmodule

`default_nettype wire

//--- memoryStage.sv
`default_nettype none

module memoryStage (
	input  logic clk,
	input  logic rst,
	memReqIf.responder memReq,
	input  cpuPkg::ctrlSig ctrlMem,
	input  logic [cpuPkg::regAddrWidth-1:0] rdMem,
	input  logic [cpuPkg::dataWidth-1:0] resMem,
	output logic [cpuPkg::dataWidth-1:0] dmemAddr,
	output logic [cpuPkg::dataWidth-1:0] dmemWData,
	output logic dmemWe,
	input  logic [cpuPkg::dataWidth-1:0] dmemRData,
	output logic wbWe,
	output logic [cpuPkg::regAddrWidth-1:0] wbRd,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic hlt
);

	// External data port
	assign dmemAddr = memReq.addr;
	assign dmemWData = memReq.wdata;
	// we is the store enable of the EX/MEM control word
	assign dmemWe = memReq.we;
	// Read data comes back combinationally
	assign memReq.rdata = dmemRData;

	// MEM/WB control
	always_ff @(posedge clk) begin
		if (rst) begin
			wbWe <= 1'b0;
			hlt <= 1'b0;
		end else begin
			wbWe <= ctrlMem.regWrite;
			// Halt bit of MEM/WB, held until reset
			hlt <= hlt | ctrlMem.isHalt;
		end
	end

	// MEM/WB payload, loaded word or execute result
	always_ff @(posedge clk) begin
		wbRd <= rdMem;
		wbData <= memReq.re ? memReq.rdata : resMem;
	end

endmodule

`default_nettype wire

//--- executeStage.sv
`default_nettype none

module executeStage (
	input  logic clk,
	input  logic rst,
	input  cpuPkg::ctrlSig ctrlEx,
	input  logic [cpuPkg::regAddrWidth-1:0] rsEx,
	input  logic [cpuPkg::regAddrWidth-1:0] rtEx,
	input  logic [cpuPkg::regAddrWidth-1:0] rdEx,
	input  logic [cpuPkg::dataWidth-1:0] opAEx,
	input  logic [cpuPkg::dataWidth-1:0] opBEx,
	input  logic [cpuPkg::dataWidth-1:0] immEx,
	input  cpuPkg::condCode condEx,
	input  logic [cpuPkg::dataWidth-1:0] pcEx,
	input  logic [cpuPkg::dataWidth-1:0] wbData,
	input  logic wbWe,
	input  logic [cpuPkg::regAddrWidth-1:0] wbRd,
	output logic brTaken,
	output logic [cpuPkg::dataWidth-1:0] brTarget,
	memReqIf.requester memReq,
	output logic [cpuPkg::regAddrWidth-1:0] rdMem,
	output cpuPkg::ctrlSig ctrlMem,
	output logic [cpuPkg::dataWidth-1:0] resMem
);
	import cpuPkg::*;

	fwdSel fwdA;
	fwdSel fwdB;
	logic [dataWidth-1:0] aVal;
	logic [dataWidth-1:0] bVal;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluRes;
	logic [dataWidth-1:0] exRes;
	logic [dataWidth-1:0] storeMem;
	logic ovf;
	logic flagZ;
	logic flagN;
	logic flagV;
	logic condTrue;

	forwardUnit fwd (
		.rsEx(rsEx),
		.rtEx(rtEx),
		.rdMem(rdMem),
		.regWriteMem(ctrlMem.regWrite),
		.wbRd(wbRd),
		.wbWe(wbWe),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

	// Operand muxes
	always_comb begin
		case (fwdA)
			fwdMem: aVal = resMem;
			fwdWb: aVal = wbData;
			default: aVal = opAEx;
		endcase
		case (fwdB)
			fwdMem: bVal = resMem;
			fwdWb: bVal = wbData;
			default: bVal = opBEx;
		endcase
	end

	// Loads and stores add the offset to the base
	assign aluB = (ctrlEx.memRead || ctrlEx.memWrite) ? immEx : bVal;

	always_comb begin
		// Logic ops leave V clear
		ovf = 1'b0;
		case (ctrlEx.aluOp)
			aluAdd: begin
				aluRes = aVal + aluB;
				ovf = (aVal[dataWidth-1] == aluB[dataWidth-1]) &&
					(aluRes[dataWidth-1] != aVal[dataWidth-1]);
			end
			aluSub: begin
				aluRes = aVal - aluB;
				ovf = (aVal[dataWidth-1] != aluB[dataWidth-1]) &&
					(aluRes[dataWidth-1] != aVal[dataWidth-1]);
			end
			aluAnd: aluRes = aVal & aluB;
			default: aluRes = aVal ^ aluB;
		endcase
	end

	// LLB/LHB merge, imm already sits in its byte lane
	assign exRes = (ctrlEx.wbSel == wbImm) ? (immEx | {8'h00, aVal[7:0]}) : aluRes;

	// Flags only move on flag-setting ALU ops
	always_ff @(posedge clk) begin
		if (rst) begin
			flagZ <= 1'b0;
			flagN <= 1'b0;
			flagV <= 1'b0;
		end else if (ctrlEx.setFlags) begin
			flagZ <= (aluRes == '0);
			flagN <= aluRes[dataWidth-1];
			flagV <= ovf;
		end
	end

	// Branch sees flags from older instructions only
	always_comb begin
		case (condEx)
			condNe: condTrue = !flagZ;
			condEq: condTrue = flagZ;
			condGt: condTrue = !flagZ && !flagN;
			condLt: condTrue = flagN;
			condGe: condTrue = flagZ || !flagN;
			condLe: condTrue = flagN || flagZ;
			condOv: condTrue = flagV;
			default: condTrue = 1'b1;
		endcase
	end

	assign brTaken = ctrlEx.isBranch && condTrue;
	// Relative to the word after the branch
	assign brTarget = pcEx + 1'b1 + immEx;

	// EX/MEM control
	always_ff @(posedge clk) begin
		if (rst) begin
			ctrlMem <= nopCtrl;
		end else begin
			ctrlMem <= ctrlEx;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		rdMem <= rdEx;
		resMem <= exRes;
		storeMem <= bVal;
	end

	assign memReq.addr = resMem;
	assign memReq.wdata = storeMem;
	assign memReq.we = ctrlMem.memWrite;
	assign memReq.re = ctrlMem.memRead;

	// Decode never issues a load and a store in one slot
	memOpExclusive: assert property (@(posedge clk) disable iff (rst)
		!(ctrlEx.memRead && ctrlEx.memWrite));

endmodule

`default_nettype wire

//--- forwardUnit.sv
`default_nettype none

module forwardUnit (
	input  logic [cpuPkg::regAddrWidth-1:0] rsEx,
	input  logic [cpuPkg::regAddrWidth-1:0] rtEx,
	input  logic [cpuPkg::regAddrWidth-1:0] rdMem,
	input  logic regWriteMem,
	input  logic [cpuPkg::regAddrWidth-1:0] wbRd,
	input  logic wbWe,
	output cpuPkg::fwdSel fwdA,
	output cpuPkg::fwdSel fwdB
);
	import cpuPkg::*;

	// Youngest producer wins, so memory is checked before writeback
	function automatic fwdSel pickSource(input logic [regAddrWidth-1:0] src);
		if (src == '0) begin
			return fwdNone;
		end else if (regWriteMem && rdMem == src) begin
			return fwdMem;
		end else if (wbWe && wbRd == src) begin
			return fwdWb;
		end
		return fwdNone;
	endfunction

	always_comb begin
		fwdA = pickSource(rsEx);
		fwdB = pickSource(rtEx);
	end

endmodule

`default_nettype wire

//--- decodeStage.sv
`default_nettype none

module decodeStage (
	input  logic clk,
	input  logic rst,
	input  logic [cpuPkg::dataWidth-1:0] instrId,
	input  logic [cpuPkg::dataWidth-1:0] pcId,
	input  logic stall,
	input  logic flush,
	input  logic wbWe,
	input  logic [cpuPkg::regAddrWidth-1:0] wbRd,
	input  logic [cpuPkg::dataWidth-1:0] wbData,
	output logic halt,
	output logic [cpuPkg::regAddrWidth-1:0] rsId,
	output logic [cpuPkg::regAddrWidth-1:0] rtId,
	output logic usesRt,
	output cpuPkg::ctrlSig ctrlEx,
	output logic [cpuPkg::regAddrWidth-1:0] rsEx,
	output logic [cpuPkg::regAddrWidth-1:0] rtEx,
	output logic [cpuPkg::regAddrWidth-1:0] rdEx,
	output logic [cpuPkg::dataWidth-1:0] opAEx,
	output logic [cpuPkg::dataWidth-1:0] opBEx,
	output logic [cpuPkg::dataWidth-1:0] immEx,
	output cpuPkg::condCode condEx,
	output logic [cpuPkg::dataWidth-1:0] pcEx
);
	import cpuPkg::*;

	opcode op;
	ctrlSig ctrlId;
	logic [dataWidth-1:0] immId;
	logic [dataWidth-1:0] rdataA;
	logic [dataWidth-1:0] rdataB;

	assign op = opcode'(instrId[15:12]);

	always_comb begin
		ctrlId = nopCtrl;
		rsId = '0;
		rtId = instrId[3:0];
		usesRt = 1'b0;
		immId = '0;
		case (op)
			opAdd, opSub, opAnd, opXor: begin
				ctrlId.regWrite = 1'b1;
				ctrlId.setFlags = 1'b1;
				// Low opcode bits select the ALU function
				ctrlId.aluOp = aluOpT'(instrId[13:12]);
				rsId = instrId[7:4];
				usesRt = 1'b1;
			end
			opLlb: begin
				// rs stays r0 so the merge sees a zero low byte
				ctrlId.regWrite = 1'b1;
				ctrlId.wbSel = wbImm;
				immId = {8'h00, instrId[7:0]};
			end
			opLhb: begin
				// Old destination value is the merge operand
				ctrlId.regWrite = 1'b1;
				ctrlId.wbSel = wbImm;
				rsId = instrId[11:8];
				immId = {instrId[7:0], 8'h00};
			end
			opLw: begin
				ctrlId.regWrite = 1'b1;
				ctrlId.memRead = 1'b1;
				ctrlId.wbSel = wbMem;
				rsId = instrId[7:4];
				immId = {12'h000, instrId[3:0]};
			end
			opSw: begin
				// Store data comes in on the rt port
				ctrlId.memWrite = 1'b1;
				rsId = instrId[7:4];
				rtId = instrId[11:8];
				usesRt = 1'b1;
				immId = {12'h000, instrId[3:0]};
			end
			opBr: begin
				ctrlId.isBranch = 1'b1;
				immId = {{7{instrId[8]}}, instrId[8:0]};
			end
			opHlt: begin
				ctrlId.isHalt = 1'b1;
			end
			default: ctrlId = nopCtrl;
		endcase
	end

	// A flush from an older branch cancels the halt
	assign halt = ctrlId.isHalt && !flush;

	regFile regs (
		.clk(clk),
		.rst(rst),
		.raddrA(rsId),
		.raddrB(rtId),
		.rdataA(rdataA),
		.rdataB(rdataB),
		.we(wbWe),
		.waddr(wbRd),
		.wdata(wbData)
	);

	// ID/EX control, bubble on load-use stall or branch flush
	always_ff @(posedge clk) begin
		if (rst || stall || flush) begin
			ctrlEx <= nopCtrl;
		end else begin
			ctrlEx <= ctrlId;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		rsEx <= rsId;
		// Unused rt must not pick up a forward
		rtEx <= usesRt ? rtId : '0;
		rdEx <= instrId[11:8];
		opAEx <= rdataA;
		opBEx <= rdataB;
		immEx <= immId;
		condEx <= condCode'(instrId[11:9]);
		pcEx <= pcId;
	end

endmodule

`default_nettype wire

//--- regFile.sv
`default_nettype none

module regFile (
	input  logic clk,
	input  logic rst,
	input  logic [cpuPkg::regAddrWidth-1:0] raddrA,
	input  logic [cpuPkg::regAddrWidth-1:0] raddrB,
	output logic [cpuPkg::dataWidth-1:0] rdataA,
	output logic [cpuPkg::dataWidth-1:0] rdataB,
	input  logic we,
	input  logic [cpuPkg::regAddrWidth-1:0] waddr,
	input  logic [cpuPkg::dataWidth-1:0] wdata
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [numRegs];
	logic writeLive;

	// r0 is never written, so it stays at its reset zero
	assign writeLive = we && (waddr != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeLive) begin
			regs[waddr] <= wdata;
		end
	end

	// Write-through, decode sees the word retiring this cycle
	assign rdataA = (writeLive && waddr == raddrA) ? wdata : regs[raddrA];
	assign rdataB = (writeLive && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

`default_nettype wire

//--- hazardDetect.sv
`default_nettype none

module hazardDetect (
	input  logic clk,
	input  logic rst,
	input  logic brTaken,
	input  logic [cpuPkg::regAddrWidth-1:0] rsId,
	input  logic [cpuPkg::regAddrWidth-1:0] rtId,
	input  logic usesRt,
	input  logic [cpuPkg::regAddrWidth-1:0] rdEx,
	input  logic memReadEx,
	output logic stall
);

	logic rsHit;
	logic rtHit;

	// rsId is zero when decode has no first source
	assign rsHit = (rsId == rdEx);
	assign rtHit = usesRt && (rtId == rdEx);

	// Load result not ready until writeback forwarding, r0 never waits
	assign stall = memReadEx && (rdEx != '0) && (rsHit || rtHit);

	// One bubble always clears the load, and a load never redirects
	stallOneCycle: assert property (@(posedge clk) disable iff (rst)
		stall |-> !brTaken ##1 !stall);

endmodule

`default_nettype wire

//--- fetchStage.sv
`default_nettype none

module fetchStage (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic halt,
	input  logic brTaken,
	input  logic [cpuPkg::dataWidth-1:0] brTarget,
	input  logic [cpuPkg::dataWidth-1:0] instr,
	output logic [cpuPkg::dataWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] instrId,
	output logic [cpuPkg::dataWidth-1:0] pcId
);
	import cpuPkg::*;

	logic halted;
	logic frozen;

	// HLT leaves decode after one cycle, so remember it
	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
		end else if (halt) begin
			halted <= 1'b1;
		end
	end

	assign frozen = halt | halted;

	// Redirect wins over stall and halt
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (brTaken) begin
			pc <= brTarget;
		end else if (!stall && !frozen) begin
			pc <= pc + 1'b1;
		end
	end

	// IF/ID instruction
	// Squashed on a redirect, starved once halted
	always_ff @(posedge clk) begin
		if (rst || brTaken || frozen) begin
			instrId <= nopInstr;
		end else if (!stall) begin
			instrId <= instr;
		end
	end

	// Address of the instruction in decode
	always_ff @(posedge clk) begin
		if (!stall) begin
			pcId <= pc;
		end
	end

endmodule

`default_nettype wire

//--- memReqIf.sv
`default_nettype none

interface memReqIf;
	import cpuPkg::*;

	// Word address, computed by the ALU
	logic [dataWidth-1:0] addr;
	// Store data, already forwarded
	logic [dataWidth-1:0] wdata;
	logic we;
	logic re;
	// Read word, returned in the same cycle
	logic [dataWidth-1:0] rdata;

	// Execute side, driven from the EX/MEM register
	modport requester (output addr, output wdata, output we, output re, input rdata);

	// Memory stage side, maps onto the external data port
	modport responder (input addr, input wdata, input we, input re, output rdata);

endinterface

`default_nettype wire

//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Word and register index widths
	localparam int dataWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int numRegs = 1 << regAddrWidth;

	// Top nibble of every instruction
	// Opcodes missing from this list decode as NOP
	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opXor = 4'd3,
		opLlb = 4'd4,
		opLhb = 4'd5,
		opLw  = 4'd8,
		opSw  = 4'd9,
		opBr  = 4'd12,
		opHlt = 4'd15
	} opcode;

	// Unused opcode, fills slots that fetch squashes
	localparam logic [dataWidth-1:0] nopInstr = 16'hE000;

	// Branch conditions, bits 11:9 of a B instruction
	typedef enum logic [2:0] {
		condNe, condEq, condGt, condLt, condGe, condLe, condOv, condAl
	} condCode;

	// Same order as the low opcode bits of the ALU ops
	typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluXor} aluOpT;

	// Writeback source
	typedef enum logic [1:0] {wbAlu, wbMem, wbImm} wbSelT;

	// Operand source picked by the forwarding logic
	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSel;

	// Decoded control word, travels down the pipe with the instruction
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic setFlags;
		logic isBranch;
		logic isHalt;
		aluOpT aluOp;
		wbSelT wbSel;
	} ctrlSig;

	// Bubble / flushed slot
	localparam ctrlSig nopCtrl = '{regWrite: 1'b0, memRead: 1'b0, memWrite: 1'b0,
		setFlags: 1'b0, isBranch: 1'b0, isHalt: 1'b0, aluOp: aluAdd, wbSel: wbAlu};

endpackage

`default_nettype wire
